/* hdl/spi_macros.svh */
//======================================
// SPI master shared constants
// Bus widths, register map, CTRL field
// positions and reset values
//======================================
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Bus and datapath widths
`define SPI_ADR_W      5
`define SPI_DATA_W     32
`define SPI_BURST_W    13
`define SPI_DIV_W      3
`define SPI_DIV_CNT_W  7

// Reset values, divider 7 gives /128
`define SPI_DIV_RESET  3'd7
`define SPI_CS_RESET   1'b1

// Register byte offsets
`define SPI_OFS_CTRL   5'h00
`define SPI_OFS_DATA   5'h04
`define SPI_OFS_STATUS 5'h08
`define SPI_OFS_CS     5'h0C
`define SPI_OFS_BURST  5'h10

// CTRL field positions
`define SPI_CTRL_CPOL_BIT 0
`define SPI_CTRL_CPHA_BIT 1
`define SPI_CTRL_DIV_LSB  2

`endif

/* hdl/spi_bus_pkg.sv */
//======================================
// SPI register-side types
// Register select decode and burst
// byte counter
//======================================
`default_nettype none

`include "spi_macros.svh"

package spi_bus_pkg;

    // Decoded Wishbone register select
    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,
        REG_DATA   = 3'd1,
        REG_STATUS = 3'd2,
        REG_CS     = 3'd3,
        REG_BURST  = 3'd4,
        REG_NONE   = 3'd5
    } spi_reg_e;

    // Remaining bytes of a burst, zero when idle
    typedef logic [`SPI_BURST_W-1:0] burst_count_t;

endpackage

`default_nettype wire

/* hdl/spi_serial_pkg.sv */
//======================================
// SPI serial-side types
// Shifter FSM state, byte, divider
//======================================
`default_nettype none

`include "spi_macros.svh"

package spi_serial_pkg;

    // Shifter FSM
    typedef enum logic [1:0] {
        SHIFT_IDLE   = 2'd0,
        SHIFT_RUN    = 2'd1,
        SHIFT_FINISH = 2'd2
    } shift_state_e;

    typedef logic [7:0] spi_byte_t;
    typedef logic [`SPI_DIV_W-1:0] clk_div_t;

endpackage

`default_nettype wire

/* hdl/spi_regs.sv */
//======================================
// SPI register block
// Wishbone classic slave with CTRL,
// DATA, STATUS, CS and BURST registers,
// burst byte counter and IRQ pulse
//======================================
`default_nettype none

`include "spi_macros.svh"

module spi_regs
    import spi_bus_pkg::*, spi_serial_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`SPI_ADR_W-1:0]  wb_adr,
    input  logic [`SPI_DATA_W-1:0] wb_wdata,
    input  logic [3:0]             wb_sel,
    output logic                   wb_ack,
    output logic [`SPI_DATA_W-1:0] wb_rdata,
    input  logic                   busy,
    input  logic                   xfer_done,
    input  spi_byte_t              rx_data,
    output logic                   cpol,
    output logic                   cpha,
    output clk_div_t               div_sel,
    output spi_byte_t              tx_data,
    output logic                   tx_start,
    output logic                   cs_n,
    output logic                   irq
);

    spi_reg_e                reg_sel;
    logic                    req;
    logic                    data_stall;
    logic                    ack_en;
    logic                    wr_req;
    logic                    data_wr;
    logic                    burst_wr;
    logic                    burst_active;
    logic                    cs_reg;
    burst_count_t            burst_count;
    burst_count_t            burst_wdata;
    logic [`SPI_DATA_W-1:0]  rdata_next;

    //======================================
    // Address decode and handshake
    //======================================
    always_comb begin
        case (wb_adr)
            `SPI_OFS_CTRL:   reg_sel = REG_CTRL;
            `SPI_OFS_DATA:   reg_sel = REG_DATA;
            `SPI_OFS_STATUS: reg_sel = REG_STATUS;
            `SPI_OFS_CS:     reg_sel = REG_CS;
            `SPI_OFS_BURST:  reg_sel = REG_BURST;
            default:         reg_sel = REG_NONE;
        endcase
    end

    // New request only, ignore the ack cycle itself
    assign req = wb_cyc && wb_stb && !wb_ack;
    // DATA write waits while a byte is in flight or about to start
    assign data_stall = wb_we && (reg_sel == REG_DATA) && (busy || tx_start);
    assign ack_en = req && !data_stall;
    assign wr_req = ack_en && wb_we;
    assign data_wr = wr_req && (reg_sel == REG_DATA) && wb_sel[0];
    assign burst_wr = wr_req && (reg_sel == REG_BURST) && (wb_sel[0] || wb_sel[1]);
    assign burst_active = (burst_count != '0);

    // Byte-lane merge for BURST
    assign burst_wdata = {wb_sel[1] ? wb_wdata[`SPI_BURST_W-1:8] : burst_count[`SPI_BURST_W-1:8],
                          wb_sel[0] ? wb_wdata[7:0] : burst_count[7:0]};

    // Read mux, unmapped reads return zero
    always_comb begin
        rdata_next = '0;
        case (reg_sel)
            REG_CTRL: begin
                rdata_next[`SPI_CTRL_CPOL_BIT] = cpol;
                rdata_next[`SPI_CTRL_CPHA_BIT] = cpha;
                rdata_next[`SPI_CTRL_DIV_LSB +: `SPI_DIV_W] = div_sel;
            end
            REG_DATA:   rdata_next[7:0] = rx_data;
            REG_STATUS: rdata_next[2:0] = {burst_active, !busy, busy};
            REG_CS:     rdata_next[0] = cs_reg;
            REG_BURST:  rdata_next[`SPI_BURST_W-1:0] = burst_count;
            default:    rdata_next = '0;
        endcase
    end

    //======================================
    // Config registers and bus response
    //======================================
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wb_ack   <= 1'b0;
            wb_rdata <= '0;
            cpol     <= 1'b0;
            cpha     <= 1'b0;
            div_sel  <= `SPI_DIV_RESET;
            cs_reg   <= `SPI_CS_RESET;
            cs_n     <= `SPI_CS_RESET;
            tx_start <= 1'b0;
        end else begin
            wb_ack   <= ack_en;
            tx_start <= data_wr;
            // Pin lags the register by one cycle
            cs_n     <= cs_reg;
            if (ack_en && !wb_we) begin
                wb_rdata <= rdata_next;
            end
            if (wr_req && wb_sel[0]) begin
                case (reg_sel)
                    REG_CTRL: begin
                        cpol    <= wb_wdata[`SPI_CTRL_CPOL_BIT];
                        cpha    <= wb_wdata[`SPI_CTRL_CPHA_BIT];
                        div_sel <= wb_wdata[`SPI_CTRL_DIV_LSB +: `SPI_DIV_W];
                    end
                    REG_CS:  cs_reg <= wb_wdata[0];
                    default: cs_reg <= cs_reg;
                endcase
            end
        end
    end

    // TX byte latch
    always_ff @(posedge clk) begin
        if (data_wr) begin
            tx_data <= wb_wdata[7:0];
        end
    end

    //======================================
    // Burst counter and IRQ
    //======================================
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            burst_count <= '0;
            irq         <= 1'b0;
        end else begin
            // Single byte or last byte of a burst
            irq <= xfer_done && (burst_count <= burst_count_t'(1));
            // Bus write has priority over the decrement
            if (burst_wr) begin
                burst_count <= burst_wdata;
            end else if (xfer_done && burst_active) begin
                burst_count <= burst_count - 1'b1;
            end
        end
    end

    // Ack always answers an earlier request
    ack_after_req: assert property (@(posedge clk) disable iff (!resetn)
        wb_ack |-> $past(wb_cyc && wb_stb));

    // Shifter never gets a start while busy
    start_not_busy: assert property (@(posedge clk) disable iff (!resetn)
        tx_start |-> !busy);

endmodule

`default_nettype wire

/* hdl/spi_clk_div.sv */
//======================================
// SPI bit-rate divider
// Free-running power-of-two tick,
// one pulse every 2^div_sel clocks
//======================================
`default_nettype none

`include "spi_macros.svh"

module spi_clk_div
    import spi_serial_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  clk_div_t div_sel,
    output logic     sck_tick
);

    logic [`SPI_DIV_CNT_W-1:0] div_cnt;
    logic [`SPI_DIV_CNT_W-1:0] div_limit;

    // 2^div_sel - 1
    assign div_limit = (`SPI_DIV_CNT_W'(1) << div_sel) - 1'b1;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            div_cnt  <= '0;
            sck_tick <= 1'b0;
        end else if (div_cnt >= div_limit) begin
            // Also catches a divider lowered mid-count
            div_cnt  <= '0;
            sck_tick <= 1'b1;
        end else begin
            div_cnt  <= div_cnt + 1'b1;
            sck_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/spi_shifter.sv */
//======================================
// SPI shift engine
// 8-bit MSB-first transfer in any of
// the four SPI modes, paced by sck_tick
//======================================
`default_nettype none

module spi_shifter
    import spi_serial_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      sck_tick,
    input  logic      cpol,
    input  logic      cpha,
    input  logic      tx_start,
    input  spi_byte_t tx_data,
    input  logic      miso,
    output logic      sck,
    output logic      mosi,
    output logic      busy,
    output logic      xfer_done,
    output spi_byte_t rx_data
);

    shift_state_e state;
    spi_byte_t    shift_reg;
    logic [2:0]   bit_cnt;
    logic         phase;
    logic         miso_cap;
    logic         lead_en;
    logic         trail_en;
    logic         load_en;

    // Phase 1 means sck away from its idle level
    assign sck       = cpol ^ phase;
    assign busy      = (state != SHIFT_IDLE);
    assign xfer_done = (state == SHIFT_FINISH);

    // Edge strobes
    assign load_en  = (state == SHIFT_IDLE) && tx_start;
    assign lead_en  = (state == SHIFT_RUN) && sck_tick && !phase;
    assign trail_en = (state == SHIFT_RUN) && sck_tick && phase;

    //======================================
    // Control FSM
    //======================================
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= SHIFT_IDLE;
            bit_cnt <= '0;
            phase   <= 1'b0;
            mosi    <= 1'b0;
            rx_data <= '0;
        end else begin
            case (state)
                SHIFT_IDLE: begin
                    phase <= 1'b0;
                    if (tx_start) begin
                        bit_cnt <= '0;
                        state   <= SHIFT_RUN;
                        // CPHA 0 needs MSB out before the first edge
                        if (!cpha) begin
                            mosi <= tx_data[7];
                        end
                    end
                end
                SHIFT_RUN: begin
                    if (sck_tick) begin
                        phase <= !phase;
                    end
                    if (lead_en && cpha) begin
                        mosi <= shift_reg[7];
                    end
                    if (trail_en) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        // Next bit for CPHA 0, none after the last
                        if (!cpha && bit_cnt != 3'd7) begin
                            mosi <= shift_reg[6];
                        end
                        if (bit_cnt == 3'd7) begin
                            state <= SHIFT_FINISH;
                        end
                    end
                end
                SHIFT_FINISH: begin
                    rx_data <= shift_reg;
                    state   <= SHIFT_IDLE;
                end
                default: state <= SHIFT_IDLE;
            endcase
        end
    end

    //======================================
    // Shift datapath
    //======================================
    always_ff @(posedge clk) begin
        if (load_en) begin
            shift_reg <= tx_data;
        end else if (lead_en && !cpha) begin
            // CPHA 0 samples on leading edge, shifts later
            miso_cap <= miso;
        end else if (trail_en) begin
            shift_reg <= {shift_reg[6:0], cpha ? miso : miso_cap};
        end
    end

    // Clock must rest at its idle level
    sck_idle_level: assert property (@(posedge clk) disable iff (!resetn)
        (state == SHIFT_IDLE) |-> (sck == cpol));

endmodule

`default_nettype wire

/* hdl/spi_master.sv */
//======================================
// SPI master top level
// Register block, bit-rate divider and
// shift engine behind a Wishbone port
//======================================
`default_nettype none

`include "spi_macros.svh"

module spi_master
    import spi_serial_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`SPI_ADR_W-1:0]  wb_adr,
    input  logic [`SPI_DATA_W-1:0] wb_wdata,
    input  logic [3:0]             wb_sel,
    output logic                   wb_ack,
    output logic [`SPI_DATA_W-1:0] wb_rdata,
    output logic                   sck,
    output logic                   mosi,
    output logic                   cs_n,
    input  logic                   miso,
    output logic                   irq
);

    // Register block to serial side
    logic      cpol;
    logic      cpha;
    logic      tx_start;
    logic      busy;
    logic      xfer_done;
    logic      sck_tick;
    clk_div_t  div_sel;
    spi_byte_t tx_data;
    spi_byte_t rx_data;

    spi_regs spi_regs_inst (
        .clk       (clk),
        .resetn    (resetn),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_sel    (wb_sel),
        .wb_ack    (wb_ack),
        .wb_rdata  (wb_rdata),
        .busy      (busy),
        .xfer_done (xfer_done),
        .rx_data   (rx_data),
        .cpol      (cpol),
        .cpha      (cpha),
        .div_sel   (div_sel),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .cs_n      (cs_n),
        .irq       (irq)
    );

    spi_clk_div spi_clk_div_inst (
        .clk      (clk),
        .resetn   (resetn),
        .div_sel  (div_sel),
        .sck_tick (sck_tick)
    );

    spi_shifter spi_shifter_inst (
        .clk       (clk),
        .resetn    (resetn),
        .sck_tick  (sck_tick),
        .cpol      (cpol),
        .cpha      (cpha),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .miso      (miso),
        .sck       (sck),
        .mosi      (mosi),
        .busy      (busy),
        .xfer_done (xfer_done),
        .rx_data   (rx_data)
    );

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
//======================================
// Testbench clock and reset
//======================================
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic resetn
);

    // Period 8
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held for 3 cycles, released on a falling edge
    initial begin
        resetn = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

/* test/spi_checker.sv */
//======================================
// SPI master result checker
// Counts irq pulses, compares values
// and prints one line per test
//======================================
`default_nettype none

module spi_checker (
    input logic clk,
    input logic resetn,
    input logic irq,
    input logic sck,
    input logic cs_n
);

    int    irq_count = 0;
    int    pass_count = 0;
    int    fail_count = 0;
    int    test_errors = 0;
    string cur_test = "none";

    // One count per irq pulse, sampled away from the rising edge
    always @(negedge clk) begin
        if (resetn && irq) begin
            irq_count++;
        end
    end

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic note_fail(input string msg);
        $display("ERROR %s: %s", cur_test, msg);
        test_errors++;
    endtask

    // Pin checks use the watched ports directly
    task automatic check_sck_idle(input logic exp_cpol);
        check_eq("sck idle level", 32'(exp_cpol), 32'(sck));
    endtask

    task automatic check_cs_n(input logic exp_cs);
        check_eq("cs_n pin", 32'(exp_cs), 32'(cs_n));
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("PASS %s", cur_test);
        end else begin
            fail_count++;
            $display("FAIL %s (%0d errors)", cur_test, test_errors);
        end
    endtask

    task automatic print_counts();
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    endtask

endmodule

`default_nettype wire

/* test/spi_master_tb.sv */
//======================================
// SPI master testbench
// Seeded random stimulus, SPI slave
// model, Wishbone driver and watchdog
//======================================
`default_nettype none

`include "spi_macros.svh"

module spi_master_tb;

    localparam int NUM_SINGLE = 8;
    localparam int MAX_BURST  = 6;
    localparam int NUM_BYTES  = NUM_SINGLE + 2 + MAX_BURST;
    localparam int WATCHDOG   = NUM_BYTES * 16 * 128 * 8 + 40000;
    localparam int WAIT_LIMIT = 5000;

    logic        clk;
    logic        resetn;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [4:0]  wb_adr;
    logic [31:0] wb_wdata;
    logic [3:0]  wb_sel;
    logic        wb_ack;
    logic [31:0] wb_rdata;
    logic        sck;
    logic        mosi;
    logic        cs_n;
    logic        miso;
    logic        irq;

    // Register model
    logic        m_cpol = 1'b0;
    logic        m_cpha = 1'b0;
    logic [2:0]  m_div = 3'd7;
    logic        m_cs = 1'b1;

    // Slave model state
    logic [7:0]  slv_tx = '0;
    logic [7:0]  slv_rx = '0;
    int          slv_left = 0;
    logic        sck_prev = 1'b0;
    logic        arm_req = 1'b0;
    logic        arm_seen = 1'b0;
    logic [7:0]  arm_byte = '0;
    int          arm_bytes = 0;
    logic [7:0]  rx_q[$];

    tb_clk_gen clk_gen_inst (
        .clk    (clk),
        .resetn (resetn)
    );

    spi_master spi_master_inst (
        .clk      (clk),
        .resetn   (resetn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_sel   (wb_sel),
        .wb_ack   (wb_ack),
        .wb_rdata (wb_rdata),
        .sck      (sck),
        .mosi     (mosi),
        .cs_n     (cs_n),
        .miso     (miso),
        .irq      (irq)
    );

    spi_checker checker_inst (
        .clk    (clk),
        .resetn (resetn),
        .irq    (irq),
        .sck    (sck),
        .cs_n   (cs_n)
    );

    //========================================
    // SPI slave model
    //========================================
    // Edges seen at the falling clock, so miso also changes there
    always @(negedge clk) begin
        if (arm_req != arm_seen) begin
            arm_seen = arm_req;
            slv_tx   = arm_byte;
            slv_left = arm_bytes * 8;
            if (!m_cpha) begin
                miso = arm_byte[7];
            end
        end else if (slv_left > 0 && sck != sck_prev) begin
            if ((sck != m_cpol) == !m_cpha) begin
                // Sampling edge
                slv_rx = {slv_rx[6:0], mosi};
                slv_left--;
                if (slv_left % 8 == 0) begin
                    rx_q.push_back(slv_rx);
                end
            end else begin
                // Launch edge, CPHA 1 drives before shifting
                if (m_cpha) begin
                    miso = slv_tx[7];
                end
                slv_tx = {slv_tx[6:0], 1'b0};
                if (!m_cpha) begin
                    miso = slv_tx[7];
                end
            end
        end
        sck_prev = sck;
    end

    // Hand the slave its miso byte and the number of bytes to expect
    task automatic slave_arm(input logic [7:0] b, input int n);
        arm_byte  = b;
        arm_bytes = n;
        arm_req   = ~arm_req;
        @(negedge clk);
    endtask

    //========================================
    // Wishbone driver
    //========================================
    task automatic wb_access(input logic we, input logic [4:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int n;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        wb_sel   = 4'hF;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < WAIT_LIMIT);
        if (!wb_ack) begin
            checker_inst.note_fail("bus cycle got no ack");
        end
        rdata  = wb_rdata;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [4:0] adr, input logic [31:0] wdata);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdata, unused);
    endtask

    task automatic wb_read(input logic [4:0] adr, output logic [31:0] rdata);
        wb_access(1'b0, adr, 32'h0, rdata);
    endtask

    function automatic logic [31:0] ctrl_value();
        return {27'h0, m_div, m_cpha, m_cpol};
    endfunction

    task automatic write_ctrl(input logic [31:0] v);
        m_cpol = v[0];
        m_cpha = v[1];
        m_div  = v[4:2];
        wb_write(`SPI_OFS_CTRL, v);
    endtask

    task automatic wait_irqs(input int target);
        int n;
        n = 0;
        while (checker_inst.irq_count < target && n < 3 * WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (checker_inst.irq_count < target) begin
            checker_inst.note_fail("irq pulse never arrived");
        end
    endtask

    // Poll STATUS until the busy bit clears
    task automatic wait_idle();
        logic [31:0] st;
        int          n;
        n = 0;
        do begin
            wb_read(`SPI_OFS_STATUS, st);
            n++;
        end while (st[0] && n < WAIT_LIMIT);
        if (st[0]) begin
            checker_inst.note_fail("shifter stayed busy");
        end
    endtask

    task automatic check_rx(input string what, input logic [7:0] exp);
        if (rx_q.size() == 0) begin
            checker_inst.note_fail("slave model received no byte");
        end else begin
            checker_inst.check_eq(what, 32'(exp), 32'(rx_q.pop_front()));
        end
    endtask

    //========================================
    // Test sequence
    //========================================
    initial begin
        logic [31:0] rd;
        logic [7:0]  tx;
        logic [7:0]  rx;
        logic [7:0]  tx2;
        int          base;
        int          nb;

        void'($urandom(48));
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_wdata = '0;
        wb_sel   = '0;
        miso     = 1'b0;
        @(posedge resetn);

        // Reset values and register readback
        checker_inst.begin_test("reset_and_config");
        wb_read(`SPI_OFS_CTRL, rd);
        checker_inst.check_eq("ctrl after reset", 32'h1C, rd);
        wb_read(`SPI_OFS_CS, rd);
        checker_inst.check_eq("cs after reset", 32'h1, rd);
        checker_inst.check_cs_n(1'b1);
        wb_read(`SPI_OFS_STATUS, rd);
        checker_inst.check_eq("status after reset", 32'h2, rd);
        write_ctrl({27'h0, 5'($urandom)});
        wb_read(`SPI_OFS_CTRL, rd);
        checker_inst.check_eq("ctrl readback", ctrl_value(), rd);
        m_cs = 1'($urandom);
        wb_write(`SPI_OFS_CS, {31'h0, m_cs});
        wb_read(`SPI_OFS_CS, rd);
        checker_inst.check_eq("cs readback", {31'h0, m_cs}, rd);
        checker_inst.check_cs_n(m_cs);
        m_cs = 1'b0;
        wb_write(`SPI_OFS_CS, 32'h0);
        repeat (2) @(negedge clk);
        checker_inst.check_cs_n(1'b0);
        checker_inst.end_test();

        // Single transfers in random modes
        checker_inst.begin_test("single_transfers");
        for (int i = 0; i < NUM_SINGLE; i++) begin
            write_ctrl({27'h0, 5'($urandom)});
            tx = 8'($urandom);
            rx = 8'($urandom);
            base = checker_inst.irq_count;
            slave_arm(rx, 1);
            wb_write(`SPI_OFS_DATA, {24'h0, tx});
            wait_irqs(base + 1);
            repeat (20) @(negedge clk);
            checker_inst.check_eq("irq pulses", base + 1, checker_inst.irq_count);
            check_rx("mosi byte", tx);
            wb_read(`SPI_OFS_DATA, rd);
            checker_inst.check_eq("data read", {24'h0, rx}, rd);
            checker_inst.check_sck_idle(m_cpol);
        end
        checker_inst.end_test();

        // Second DATA write stalls until the first byte is done
        checker_inst.begin_test("back_pressure");
        tx  = 8'($urandom);
        tx2 = 8'($urandom);
        base = checker_inst.irq_count;
        // Room for a third byte so a doubled transfer lands in the queue
        slave_arm(8'($urandom), 3);
        wb_write(`SPI_OFS_DATA, {24'h0, tx});
        wb_write(`SPI_OFS_DATA, {24'h0, tx2});
        checker_inst.check_eq("irq before second ack", base + 1, checker_inst.irq_count);
        wait_irqs(base + 2);
        repeat (20) @(negedge clk);
        checker_inst.check_eq("irq pulses", base + 2, checker_inst.irq_count);
        check_rx("first byte", tx);
        check_rx("second byte", tx2);
        checker_inst.check_eq("extra bytes", 0, rx_q.size());
        checker_inst.end_test();

        // Burst of N bytes, one irq at the end
        checker_inst.begin_test("burst");
        nb = 2 + int'($urandom % 5);
        wb_write(`SPI_OFS_BURST, 32'(nb));
        base = checker_inst.irq_count;
        for (int k = 1; k <= nb; k++) begin
            tx = 8'($urandom);
            rx = 8'($urandom);
            slave_arm(rx, 1);
            wb_write(`SPI_OFS_DATA, {24'h0, tx});
            wait_idle();
            wb_read(`SPI_OFS_BURST, rd);
            checker_inst.check_eq("burst remaining", 32'(nb - k), rd);
            wb_read(`SPI_OFS_STATUS, rd);
            checker_inst.check_eq("burst active", 32'(k != nb), 32'(rd[2]));
            checker_inst.check_eq("burst irq", base + int'(k == nb), checker_inst.irq_count);
            check_rx("burst byte", tx);
        end
        repeat (20) @(negedge clk);
        checker_inst.check_eq("irq after burst", base + 1, checker_inst.irq_count);
        checker_inst.end_test();

        // Unmapped address
        checker_inst.begin_test("unmapped");
        wb_write(5'h14, $urandom);
        wb_read(5'h14, rd);
        checker_inst.check_eq("unmapped read", 32'h0, rd);
        wb_read(`SPI_OFS_CTRL, rd);
        checker_inst.check_eq("ctrl kept", ctrl_value(), rd);
        wb_read(`SPI_OFS_CS, rd);
        checker_inst.check_eq("cs kept", {31'h0, m_cs}, rd);
        wb_read(`SPI_OFS_BURST, rd);
        checker_inst.check_eq("burst kept", 32'h0, rd);
        wb_read(`SPI_OFS_DATA, rd);
        checker_inst.check_eq("data kept", {24'h0, rx}, rd);
        wb_read(`SPI_OFS_STATUS, rd);
        checker_inst.check_eq("status kept", 32'h2, rd);
        checker_inst.end_test();

        checker_inst.print_counts();
        if (checker_inst.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog, sized for every byte at the slowest divider
    initial begin
        #(WATCHDOG);
        $display("Timeout: simulation ran past %0d time units", WATCHDOG);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/spi_bus_pkg.sv
hdl/spi_serial_pkg.sv
hdl/spi_regs.sv
hdl/spi_clk_div.sv
hdl/spi_shifter.sv
hdl/spi_master.sv
test/tb_clk_gen.sv
test/spi_checker.sv
test/spi_master_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module spi_master_tb -Mdir obj_dir \
    && ./obj_dir/Vspi_master_tb | tee /dev/stderr | grep -qx "Test passed" \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
